// File: verilog/testbus_pkg.sv
package testbus_pkg;

   // ********************
   // Test bus word and slot select
   typedef logic [15:0] word_t;
   typedef logic [5:0]  sel_t;

   // One lane sample as seen by the monitor
   typedef struct packed {
      logic  valid;
      logic  err;
      word_t data;
   } lane_sample_t;

   localparam int    MON_SLOTS = 32;
   localparam word_t SIGNATURE = 16'haa55;

   // ********************
   // Slot numbering, slot 0 is the signature
   localparam int SLOT_VALID_CNT = 1;
   localparam int SLOT_ERR_CNT   = 2;
   localparam int SLOT_LAST_DATA = 3;
   localparam int SLOT_MAX_DATA  = 4;
   localparam int SLOT_MIN_DATA  = 5;
   localparam int SLOT_CHECKSUM  = 6;

   // Values one lane monitor produces
   localparam int MON_COUNT = 6;

endpackage

// File: verilog/apb_pkg.sv
package apb_pkg;

   typedef logic [7:0] addr_t;

   // ********************
   // APB request, driven by the master
   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      addr_t       paddr;
      logic [31:0] pwdata;
   } apb_req_t;

   // APB response, driven by the slave
   typedef struct packed {
      logic        pready;
      logic        pslverr;
      logic [31:0] prdata;
   } apb_rsp_t;

   // ********************
   // Register map, lane n select sits at ADDR_SEL_BASE + 4n
   localparam addr_t ADDR_SEL_BASE = 8'h00;
   localparam addr_t ADDR_RDSEL    = 8'h10;
   localparam addr_t ADDR_DATA     = 8'h14;
   localparam addr_t ADDR_CLR      = 8'h18;

endpackage

// File: verilog/lane_stat_mon.sv
`timescale 1ns/1ps

module lane_stat_mon #(
   parameter int NUM_MON = testbus_pkg::MON_COUNT
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  testbus_pkg::lane_sample_t sample,
   input  logic                      clr,
   output testbus_pkg::word_t        mon [NUM_MON]
);

   testbus_pkg::word_t valid_cnt;
   testbus_pkg::word_t err_cnt;
   testbus_pkg::word_t last_data;
   testbus_pkg::word_t max_data;
   testbus_pkg::word_t min_data;
   testbus_pkg::word_t checksum;
   testbus_pkg::word_t stat [testbus_pkg::MON_COUNT];

   // ********************
   // Statistics, clear wins over a sample in the same cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_cnt <= '0;
         err_cnt   <= '0;
         last_data <= '0;
         max_data  <= '0;
         min_data  <= 16'hffff;
         checksum  <= '0;
      end else if (clr) begin
         valid_cnt <= '0;
         err_cnt   <= '0;
         last_data <= '0;
         max_data  <= '0;
         min_data  <= 16'hffff;
         checksum  <= '0;
      end else if (sample.valid) begin
         // Counters wrap at 16 bits
         valid_cnt <= valid_cnt + 16'd1;
         if (sample.err) begin
            err_cnt <= err_cnt + 16'd1;
         end
         last_data <= sample.data;
         if (sample.data > max_data) begin
            max_data <= sample.data;
         end
         if (sample.data < min_data) begin
            min_data <= sample.data;
         end
         checksum <= checksum ^ sample.data;
      end
   end

   // ********************
   // Output index i carries slot i+1
   assign stat[testbus_pkg::SLOT_VALID_CNT - 1] = valid_cnt;
   assign stat[testbus_pkg::SLOT_ERR_CNT - 1]   = err_cnt;
   assign stat[testbus_pkg::SLOT_LAST_DATA - 1] = last_data;
   assign stat[testbus_pkg::SLOT_MAX_DATA - 1]  = max_data;
   assign stat[testbus_pkg::SLOT_MIN_DATA - 1]  = min_data;
   assign stat[testbus_pkg::SLOT_CHECKSUM - 1]  = checksum;

   for (genvar i = 0; i < NUM_MON; i++) begin : g_mon
      if (i < testbus_pkg::MON_COUNT) begin : g_stat
         assign mon[i] = stat[i];
      end else begin : g_unused
         assign mon[i] = '0;
      end
   end

   // Error count only moves on a valid sample or a clear
   a_err_cnt_hold: assert property (@(posedge clk) disable iff (!rst_n)
      !sample.valid && !clr |=> $stable(err_cnt));

endmodule

// File: verilog/mon_mux_lane.sv
`timescale 1ns/1ps

module mon_mux_lane #(
   parameter int NUM_MON = testbus_pkg::MON_COUNT
) (
   input  testbus_pkg::sel_t  sel,
   input  testbus_pkg::word_t mon [NUM_MON],
   output testbus_pkg::word_t dig_test_dout_lane
);

   // ********************
   // Slot 0 is the signature, slots past the monitor values read zero
   always_comb begin
      dig_test_dout_lane = '0;
      if (sel == '0) begin
         dig_test_dout_lane = testbus_pkg::SIGNATURE;
      end
      for (int i = 1; i <= NUM_MON; i++) begin
         if (i < testbus_pkg::MON_SLOTS && int'(sel) == i) begin
            dig_test_dout_lane = mon[i - 1];
         end
      end
   end

   // Checked after the mux settles
   always_comb begin
      if (sel == '0) begin
         a_sel_signature: assert final (dig_test_dout_lane == testbus_pkg::SIGNATURE);
      end
      if (int'(sel) > NUM_MON) begin
         a_sel_zero: assert final (dig_test_dout_lane == '0);
      end
   end

endmodule

// File: verilog/testbus_regs.sv
`timescale 1ns/1ps

module testbus_regs #(
   parameter int NUM_LANES = 2
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  apb_pkg::apb_req_t     apb_req,
   output apb_pkg::apb_rsp_t     apb_rsp,
   output testbus_pkg::sel_t     sel [NUM_LANES],
   output logic [NUM_LANES-1:0]  clr,
   input  testbus_pkg::word_t    lane_dout [NUM_LANES]
);

   localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

   logic                 access;
   logic [NUM_LANES-1:0] sel_hit;
   logic                 hit_rdsel;
   logic                 hit_data;
   logic                 hit_clr;
   logic                 err;
   logic                 wr_ok;
   logic [LANE_W-1:0]    rdsel;
   logic [31:0]          rdata;

   // ********************
   // Address decode
   assign access = apb_req.psel && apb_req.penable;

   for (genvar n = 0; n < NUM_LANES; n++) begin : g_hit
      assign sel_hit[n] = (apb_req.paddr == apb_pkg::ADDR_SEL_BASE + 8'(4 * n));
   end

   assign hit_rdsel = (apb_req.paddr == apb_pkg::ADDR_RDSEL);
   assign hit_data  = (apb_req.paddr == apb_pkg::ADDR_DATA);
   assign hit_clr   = (apb_req.paddr == apb_pkg::ADDR_CLR);

   // Unmapped address, DATA is read only, RDSEL past the last lane
   assign err = !(|sel_hit || hit_rdsel || hit_data || hit_clr)
              || (apb_req.pwrite && hit_data)
              || (apb_req.pwrite && hit_rdsel && apb_req.pwdata >= 32'(NUM_LANES));

   assign wr_ok = access && apb_req.pwrite && !err;

   // ********************
   // Registers
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int n = 0; n < NUM_LANES; n++) begin
            sel[n] <= '0;
         end
         rdsel <= '0;
      end else if (wr_ok) begin
         for (int n = 0; n < NUM_LANES; n++) begin
            if (sel_hit[n]) begin
               sel[n] <= apb_req.pwdata[5:0];
            end
         end
         if (hit_rdsel) begin
            rdsel <= apb_req.pwdata[LANE_W-1:0];
         end
      end
   end

   // One cycle clear pulse per lane
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         clr <= '0;
      end else if (wr_ok && hit_clr) begin
         clr <= apb_req.pwdata[NUM_LANES-1:0];
      end else begin
         clr <= '0;
      end
   end

   // ********************
   // Read data, CLR reads zero
   always_comb begin
      rdata = '0;
      for (int n = 0; n < NUM_LANES; n++) begin
         if (sel_hit[n]) begin
            rdata = 32'(sel[n]);
         end
      end
      if (hit_rdsel) begin
         rdata = 32'(rdsel);
      end
      if (hit_data) begin
         rdata = 32'(lane_dout[rdsel]);
      end
   end

   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.pslverr = access && err;
   assign apb_rsp.prdata  = rdata;

   // Access phase always follows a setup phase
   a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
      apb_req.penable |-> apb_req.psel && $past(apb_req.psel && !apb_req.penable));

endmodule

// File: verilog/testbus_top.sv
`timescale 1ns/1ps

module testbus_top #(
   parameter int NUM_LANES = 2,
   parameter int NUM_MON   = testbus_pkg::MON_COUNT
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  apb_pkg::apb_req_t         apb_req,
   output apb_pkg::apb_rsp_t         apb_rsp,
   input  testbus_pkg::lane_sample_t lanes [NUM_LANES],
   output testbus_pkg::word_t        dig_test_dout [NUM_LANES]
);

   testbus_pkg::sel_t    sel [NUM_LANES];
   logic [NUM_LANES-1:0] clr;

   // ********************
   // Register block
   testbus_regs #(
      .NUM_LANES (NUM_LANES)
   ) testbus_regs_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .apb_req   (apb_req),
      .apb_rsp   (apb_rsp),
      .sel       (sel),
      .clr       (clr),
      .lane_dout (dig_test_dout)
   );

   // ********************
   // One monitor and one test bus mux per lane
   for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane
      testbus_pkg::word_t mon [NUM_MON];

      lane_stat_mon #(
         .NUM_MON (NUM_MON)
      ) lane_stat_mon_i (
         .clk    (clk),
         .rst_n  (rst_n),
         .sample (lanes[n]),
         .clr    (clr[n]),
         .mon    (mon)
      );

      mon_mux_lane #(
         .NUM_MON (NUM_MON)
      ) mon_mux_lane_i (
         .sel                (sel[n]),
         .mon                (mon),
         .dig_test_dout_lane (dig_test_dout[n])
      );
   end

endmodule

// File: dv/testbus_top_tb.sv
`timescale 1ns/1ps

module testbus_top_tb;

   localparam int NUM_LANES = 2;
   localparam int TIMEOUT   = 20;

   typedef enum int {ST_WR, ST_RD, ST_RUN, ST_CHK} step_kind_e;

   // Table row, data also holds the cycle count of a run step
   typedef struct {
      step_kind_e     kind;
      apb_pkg::addr_t addr;
      logic [31:0]    data;
      logic [31:0]    exp;
      bit             err;
      bit             from_model;
   } step_t;

   logic                      clk;
   logic                      rst_n;
   apb_pkg::apb_req_t         apb_req;
   apb_pkg::apb_rsp_t         apb_rsp;
   testbus_pkg::lane_sample_t lanes [NUM_LANES];
   testbus_pkg::word_t        dig_test_dout [NUM_LANES];

   step_t               steps [$];
   logic [31:0]         rnd_state;
   testbus_pkg::word_t  m_stat [NUM_LANES][testbus_pkg::MON_COUNT];
   testbus_pkg::sel_t   m_sel [NUM_LANES];
   int                  m_rdsel;

   testbus_top #(
      .NUM_LANES (NUM_LANES)
   ) testbus_top_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .apb_req       (apb_req),
      .apb_rsp       (apb_rsp),
      .lanes         (lanes),
      .dig_test_dout (dig_test_dout)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // ********************
   // Reference model of the lane statistics and the slot mux
   task model_clear(input int lane);
      for (int i = 0; i < testbus_pkg::MON_COUNT; i++) begin
         m_stat[lane][i] = '0;
      end
      m_stat[lane][testbus_pkg::SLOT_MIN_DATA - 1] = 16'hffff;
   endtask

   task model_sample(input int lane, input testbus_pkg::lane_sample_t s);
      if (s.valid) begin
         m_stat[lane][testbus_pkg::SLOT_VALID_CNT - 1] += 16'd1;
         if (s.err) begin
            m_stat[lane][testbus_pkg::SLOT_ERR_CNT - 1] += 16'd1;
         end
         m_stat[lane][testbus_pkg::SLOT_LAST_DATA - 1] = s.data;
         if (s.data > m_stat[lane][testbus_pkg::SLOT_MAX_DATA - 1]) begin
            m_stat[lane][testbus_pkg::SLOT_MAX_DATA - 1] = s.data;
         end
         if (s.data < m_stat[lane][testbus_pkg::SLOT_MIN_DATA - 1]) begin
            m_stat[lane][testbus_pkg::SLOT_MIN_DATA - 1] = s.data;
         end
         m_stat[lane][testbus_pkg::SLOT_CHECKSUM - 1] ^= s.data;
      end
   endtask

   function automatic testbus_pkg::word_t model_word(input int lane, input testbus_pkg::sel_t s);
      if (s == 0) begin
         return testbus_pkg::SIGNATURE;
      end else if (int'(s) <= testbus_pkg::MON_COUNT) begin
         return m_stat[lane][s - 1];
      end
      return '0;
   endfunction

   task model_write(input apb_pkg::addr_t addr, input logic [31:0] data);
      for (int n = 0; n < NUM_LANES; n++) begin
         if (addr == apb_pkg::ADDR_SEL_BASE + 8'(4 * n)) begin
            m_sel[n] = data[5:0];
         end
         if (addr == apb_pkg::ADDR_CLR && data[n]) begin
            model_clear(n);
         end
      end
      if (addr == apb_pkg::ADDR_RDSEL) begin
         m_rdsel = int'(data);
      end
   endtask

   // ********************
   // Checks
   task stop_with_failure(input string why);
      if (why != "") begin
         $display("%s", why);
      end
      $display("Test failures found");
      $fatal(1);
   endtask

   task check_word(input string name, input testbus_pkg::word_t got,
                   input testbus_pkg::word_t exp);
      if (got !== exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         stop_with_failure("");
      end
   endtask

   task check_rsp(input string name, input apb_pkg::apb_rsp_t got,
                  input apb_pkg::apb_rsp_t exp, input bit with_data);
      // prdata means nothing on a write
      if (!with_data) begin
         exp.prdata = got.prdata;
      end
      if (got !== exp) begin
         $display("FAIL %s pslverr %h prdata %h expected pslverr %h prdata %h",
                  name, got.pslverr, got.prdata, exp.pslverr, exp.prdata);
         stop_with_failure("");
      end
   endtask

   task check_lanes();
      @(negedge clk);
      for (int n = 0; n < NUM_LANES; n++) begin
         check_word($sformatf("dig_test_dout[%0d]", n), dig_test_dout[n],
                    model_word(n, m_sel[n]));
      end
      @(posedge clk);
      #1;
   endtask

   // ********************
   // Stimulus
   task apb_transfer(input bit write, input apb_pkg::addr_t addr, input logic [31:0] wdata,
                     output apb_pkg::apb_rsp_t rsp);
      int cnt;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(posedge clk);
      #1;
      apb_req.penable = 1'b1;
      cnt = 0;
      @(negedge clk);
      while (!apb_rsp.pready) begin
         if (cnt == TIMEOUT) begin
            stop_with_failure("APB transfer never saw pready");
         end
         cnt++;
         @(negedge clk);
      end
      rsp = apb_rsp;
      @(posedge clk);
      #1;
      apb_req = '0;
      // Idle cycle so a clear pulse is over before the next step
      @(posedge clk);
      #1;
   endtask

   task run_samples(input int cycles);
      testbus_pkg::lane_sample_t s;
      repeat (cycles) begin
         for (int n = 0; n < NUM_LANES; n++) begin
            rnd_state = xorshift32(rnd_state);
            s.valid   = rnd_state[0] | rnd_state[1];
            s.err     = rnd_state[2];
            s.data    = rnd_state[31:16];
            lanes[n]  = s;
            model_sample(n, s);
         end
         @(posedge clk);
         #1;
      end
      for (int n = 0; n < NUM_LANES; n++) begin
         lanes[n] = '0;
      end
   endtask

   task add_step(input step_kind_e kind, input apb_pkg::addr_t addr, input logic [31:0] data,
                 input logic [31:0] exp, input bit err, input bit from_model);
      step_t st;
      st = '{kind, addr, data, exp, err, from_model};
      steps.push_back(st);
   endtask

   task add_sel_pair(input int sel0, input int sel1);
      add_step(ST_WR, apb_pkg::ADDR_SEL_BASE, 32'(sel0), 0, 0, 0);
      add_step(ST_WR, apb_pkg::ADDR_SEL_BASE + 8'd4, 32'(sel1), 0, 0, 0);
      add_step(ST_CHK, 0, 0, 0, 0, 0);
   endtask

   task build_table();
      // Reset state shows the signature everywhere
      add_step(ST_CHK, 0, 0, 0, 0, 0);
      add_step(ST_RD, apb_pkg::ADDR_DATA, 0, 0, 0, 1);
      add_step(ST_RUN, 0, 40, 0, 0, 0);
      for (int s = 1; s <= testbus_pkg::MON_COUNT; s++) begin
         add_sel_pair(s, s);
         add_step(ST_WR, apb_pkg::ADDR_RDSEL, 0, 0, 0, 0);
         add_step(ST_RD, apb_pkg::ADDR_DATA, 0, 0, 0, 1);
         add_step(ST_WR, apb_pkg::ADDR_RDSEL, 1, 0, 0, 0);
         add_step(ST_RD, apb_pkg::ADDR_DATA, 0, 0, 0, 1);
      end
      add_sel_pair(7, 7);
      add_sel_pair(31, 31);
      add_sel_pair(32, 32);
      add_sel_pair(63, 63);
      add_sel_pair(testbus_pkg::SLOT_LAST_DATA, testbus_pkg::SLOT_CHECKSUM);
      add_step(ST_RD, apb_pkg::ADDR_SEL_BASE, 0, 32'(testbus_pkg::SLOT_LAST_DATA), 0, 0);
      add_step(ST_RD, apb_pkg::ADDR_SEL_BASE + 8'd4, 0, 32'(testbus_pkg::SLOT_CHECKSUM), 0, 0);
      // Clear lane 1 only
      add_step(ST_RUN, 0, 30, 0, 0, 0);
      add_step(ST_WR, apb_pkg::ADDR_CLR, 32'h2, 0, 0, 0);
      for (int s = 1; s <= testbus_pkg::MON_COUNT; s++) begin
         add_sel_pair(s, s);
      end
      add_step(ST_WR, apb_pkg::ADDR_RDSEL, 1, 0, 0, 0);
      add_step(ST_WR, apb_pkg::ADDR_SEL_BASE + 8'd4, 32'(testbus_pkg::SLOT_MIN_DATA), 0, 0, 0);
      add_step(ST_RD, apb_pkg::ADDR_DATA, 0, 32'h0000ffff, 0, 0);
      add_step(ST_WR, apb_pkg::ADDR_SEL_BASE + 8'd4, 32'(testbus_pkg::SLOT_MAX_DATA), 0, 0, 0);
      add_step(ST_RD, apb_pkg::ADDR_DATA, 0, 32'h0, 0, 0);
      add_step(ST_RD, apb_pkg::ADDR_CLR, 0, 32'h0, 0, 0);
      // Error responses leave the registers alone
      add_step(ST_RUN, 0, 20, 0, 0, 0);
      add_sel_pair(testbus_pkg::SLOT_LAST_DATA, testbus_pkg::SLOT_CHECKSUM);
      add_step(ST_RD, 8'h20, 0, 32'h0, 1, 0);
      add_step(ST_WR, apb_pkg::ADDR_DATA, 32'h1234, 0, 1, 0);
      add_step(ST_WR, apb_pkg::ADDR_RDSEL, 2, 0, 1, 0);
      add_step(ST_RD, apb_pkg::ADDR_SEL_BASE, 0, 32'(testbus_pkg::SLOT_LAST_DATA), 0, 0);
      add_step(ST_RD, apb_pkg::ADDR_SEL_BASE + 8'd4, 0, 32'(testbus_pkg::SLOT_CHECKSUM), 0, 0);
      add_step(ST_RD, apb_pkg::ADDR_RDSEL, 0, 32'h1, 0, 0);
      add_step(ST_RD, apb_pkg::ADDR_DATA, 0, 0, 0, 1);
      add_step(ST_CHK, 0, 0, 0, 0, 0);
   endtask

   // ********************
   // Main sequence
   initial begin
      apb_pkg::apb_rsp_t rsp;
      logic [31:0]       exp;
      step_t             st;
      apb_req    = '0;
      rst_n      = 1'b0;
      rnd_state  = 32'd45752;
      m_rdsel    = 0;
      for (int n = 0; n < NUM_LANES; n++) begin
         lanes[n] = '0;
         m_sel[n] = '0;
         model_clear(n);
      end
      build_table();
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      foreach (steps[i]) begin
         st = steps[i];
         case (st.kind)
            ST_WR: begin
               apb_transfer(1'b1, st.addr, st.data, rsp);
               check_rsp($sformatf("apb write %h", st.addr), rsp, '{1'b1, st.err, 32'h0}, 1'b0);
               if (!st.err) begin
                  model_write(st.addr, st.data);
               end
            end
            ST_RD: begin
               apb_transfer(1'b0, st.addr, 32'h0, rsp);
               exp = st.exp;
               if (st.from_model) begin
                  exp = 32'(model_word(m_rdsel, m_sel[m_rdsel]));
               end
               check_rsp($sformatf("apb read %h", st.addr), rsp, '{1'b1, st.err, exp}, 1'b1);
            end
            ST_RUN: run_samples(int'(st.data));
            default: check_lanes();
         endcase
      end
      $display("All tests passed!");
      $finish;
   end

endmodule

// File: testbus_top.f
verilog/testbus_pkg.sv
verilog/apb_pkg.sv
verilog/lane_stat_mon.sv
verilog/mon_mux_lane.sv
verilog/testbus_regs.sv
verilog/testbus_top.sv
dv/testbus_top_tb.sv
